//--- src.f
logic/mem_wb_pkg.sv
logic/data_mem.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/mem_wb_top.sv
verif/mem_wb_tb.sv

//--- Bender.yml
# Memory and write-back back end of a 16-bit five-stage pipeline
package:
  name: mem_wb

sources:
  # Package first, every module imports it
  - logic/mem_wb_pkg.sv
  # Leaf modules before the stages that use them
  - logic/data_mem.sv
  - logic/mem_stage.sv
  - logic/wb_stage.sv
  # RTL top level
  - logic/mem_wb_top.sv

  # Simulation only
  - target: test
    files:
      - verif/mem_wb_tb.sv

//--- verif/mem_wb_tb.sv
// Testbench for the memory and write-back back end
// Drives LFSR stimulus on the falling edge, tracks memory in a reference model
// and checks every write-back output one cycle later with concurrent assertions
`timescale 1ns/1ps

module mem_wb_tb;
   import mem_wb_pkg::*;

   ////////////////////////////////////////
   // Run length
   ////////////////////////////////////////

   localparam int reset_cycles = 10;
   // Reset plus one bubble to see wb_en stay low
   localparam int reset_len = reset_cycles + 1;
   // Window fill, then 40 store/load pairs
   localparam int store_load_len = 16 + 40 * 2;
   localparam int store_update_len = 8 * 2;
   localparam int non_memory_len = 7 * 2 + 4 * 2;
   localparam int link_len = 8;
   localparam int mixed_len = 100;
   // Closing bubble and the edge that checks it
   localparam int close_len = 2;
   localparam int num_tests = 6;
   localparam int max_cycles = reset_len + store_load_len + store_update_len
                             + non_memory_len + link_len + mixed_len
                             + num_tests * close_len + 50;

   // Bubble opcode, no memory access and no link
   localparam logic [opcode_w-1:0] op_nop = 5'b00001;

   logic              clk;
   logic              rst;
   logic [word_w-1:0] instruction;
   logic [word_w-1:0] pc_incr;
   logic [word_w-1:0] b_operand;
   logic [word_w-1:0] alu_result;
   logic              reg_write;
   logic              wb_en;
   logic [reg_w-1:0]  wb_reg;
   logic [word_w-1:0] wb_data;

   // Reference memory, same word indexing as the DUT
   logic [word_w-1:0] ref_mem [mem_depth];

   // Expected outputs for the instruction taken at the last edge
   logic              rec_valid = 1'b0;
   logic              exp_en;
   logic [reg_w-1:0]  exp_reg;
   logic [word_w-1:0] exp_data;

   logic [31:0] lfsr_state = 32'h0ed1430f;
   string       cur_test = "none";
   int          err_cnt = 0;
   int          test_err_start = 0;
   int          pass_tests = 0;
   int          fail_tests = 0;
   int          cycle_cnt = 0;

   mem_wb_top u_dut (
      .clk         (clk),
      .rst         (rst),
      .instruction (instruction),
      .pc_incr     (pc_incr),
      .b_operand   (b_operand),
      .alu_result  (alu_result),
      .reg_write   (reg_write),
      .wb_en       (wb_en),
      .wb_reg      (wb_reg),
      .wb_data     (wb_data)
   );

   // 40 ns period
   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = ~clk;
      end
   end

   ////////////////////////////////////////
   // Random source
   ////////////////////////////////////////

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         r[i] = lfsr_state[0];
      end
      return r;
   endfunction

   function automatic logic rand_bit();
      logic [31:0] r;
      r = rand_bits(1);
      return r[0];
   endfunction

   function automatic logic [word_w-1:0] rand_word();
      logic [31:0] r;
      r = rand_bits(16);
      return r[15:0];
   endfunction

   // 16-word window, low byte bit random
   function automatic logic [word_w-1:0] rand_addr();
      logic [31:0] r;
      r = rand_bits(5);
      return {11'd0, r[4:0]};
   endfunction

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // Runs at the falling edge on the inputs the DUT took at the rising edge before
   task automatic record_expected();
      logic [word_w-1:0]   ins;
      logic [word_w-1:0]   pc;
      logic [word_w-1:0]   alu;
      logic                rw;
      logic [opcode_w-1:0] op;
      logic [opcode_w-1:0] in_op;
      // Reset empties the pipeline register
      if (rst) begin
         ins = '0;
         pc = '0;
         alu = '0;
         rw = 1'b0;
      end else begin
         ins = instruction;
         pc = pc_incr;
         alu = alu_result;
         rw = reg_write;
      end
      op = ins[15:11];
      exp_en = rw;
      // Value: loaded word, return address or ALU result
      if (op == op_ld) begin
         exp_data = ref_mem[alu[mem_aw:1]];
      end else if (op == op_jal || op == op_jalr) begin
         exp_data = pc;
      end else begin
         exp_data = alu;
      end
      // Destination by instruction format
      if (op == op_r_a || op == op_r_b) begin
         exp_reg = ins[4:2];
      end else if (op == op_jal || op == op_jalr) begin
         exp_reg = link_reg;
      end else if (op == op_lbi || op == op_slbi || op == op_btr || op == op_stu) begin
         exp_reg = ins[10:8];
      end else begin
         exp_reg = ins[7:5];
      end
      // Store lands after the load value was read
      // Memory has no reset, so reset does not block it
      in_op = instruction[15:11];
      if (in_op == op_st || in_op == op_stu) begin
         ref_mem[alu_result[mem_aw:1]] = b_operand;
      end
      rec_valid = 1'b1;
   endtask

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   task automatic note_mismatch(input string field, input logic [15:0] exp,
                                input logic [15:0] act);
      $display("Mismatch in %s: %s expected 0x%h, actual 0x%h", cur_test, field, exp, act);
      err_cnt++;
   endtask

   check_en: assert property (@(posedge clk) rec_valid |-> (wb_en == exp_en))
      else note_mismatch("wb_en", 16'(exp_en), 16'($sampled(wb_en)));

   check_reg: assert property (@(posedge clk) rec_valid |-> (wb_reg == exp_reg))
      else note_mismatch("wb_reg", 16'(exp_reg), 16'($sampled(wb_reg)));

   check_data: assert property (@(posedge clk) rec_valid |-> (wb_data == exp_data))
      else note_mismatch("wb_data", exp_data, $sampled(wb_data));

   // Hard stop on a hung run
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > max_cycles) begin
         $display("Timeout: run did not finish within %0d cycles", max_cycles);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Drivers
   ////////////////////////////////////////

   // One instruction per falling edge
   task automatic drive_cycle(input logic rst_v, input logic [15:0] ins_v,
                              input logic [15:0] pc_v, input logic [15:0] b_v,
                              input logic [15:0] alu_v, input logic rw_v);
      @(negedge clk);
      record_expected();
      rst = rst_v;
      instruction = ins_v;
      pc_incr = pc_v;
      b_operand = b_v;
      alu_result = alu_v;
      reg_write = rw_v;
   endtask

   // Random register fields and PC around a given opcode
   task automatic issue(input logic [4:0] op, input logic [15:0] alu_v,
                        input logic [15:0] b_v, input logic rw_v);
      logic [31:0]       fields;
      logic [word_w-1:0] pc_v;
      fields = rand_bits(11);
      pc_v = rand_word();
      drive_cycle(1'b0, {op, fields[10:0]}, pc_v, b_v, alu_v, rw_v);
   endtask

   task automatic open_test(input string name);
      cur_test = name;
      test_err_start = err_cnt;
   endtask

   // Bubble pushes the last instruction through its check
   task automatic close_test();
      issue(op_nop, 16'h0000, 16'h0000, 1'b0);
      @(posedge clk);
      #1;
      if (err_cnt == test_err_start) begin
         pass_tests++;
         $display("Test %s: pass", cur_test);
      end else begin
         fail_tests++;
         $display("Test %s: fail with %0d mismatches", cur_test, err_cnt - test_err_start);
      end
   endtask

   ////////////////////////////////////////
   // Tests
   ////////////////////////////////////////

   // reg_write held high, wb_en must stay low
   task automatic apply_reset();
      logic [31:0] fields;
      open_test("reset");
      repeat (reset_cycles - 1) begin
         fields = rand_bits(11);
         drive_cycle(1'b1, {op_r_a, fields[10:0]}, rand_word(), 16'h0, rand_word(), 1'b1);
      end
      issue(op_r_b, rand_word(), 16'h0000, 1'b0);
      close_test();
   endtask

   task automatic store_load_pairs();
      logic [word_w-1:0] addr;
      logic [word_w-1:0] ld_addr;
      logic [word_w-1:0] data;
      open_test("store_load");
      // Every window word known before the first load
      for (int w = 0; w < 16; w++) begin
         data = rand_word();
         issue(op_st, 16'(w * 2), data, rand_bit());
      end
      for (int n = 0; n < 40; n++) begin
         addr = rand_addr();
         data = rand_word();
         issue(op_st, addr, data, rand_bit());
         // Back-to-back hit on about half the pairs
         if (rand_bit()) begin
            ld_addr = addr;
         end else begin
            ld_addr = rand_addr();
         end
         issue(op_ld, ld_addr, rand_word(), rand_bit());
      end
      close_test();
   endtask

   task automatic store_update_checks();
      logic [word_w-1:0] addr;
      logic [word_w-1:0] data;
      open_test("store_update");
      repeat (8) begin
         addr = rand_addr();
         data = rand_word();
         issue(op_stu, addr, data, 1'b1);
         issue(op_ld, addr, rand_word(), 1'b1);
      end
      close_test();
   endtask

   task automatic non_memory_ops();
      logic [opcode_w-1:0] ops [7];
      logic [word_w-1:0]   addr;
      ops = '{op_r_a, op_r_b, op_lbi, op_btr, op_slbi, 5'b01000, 5'b00101};
      open_test("non_memory");
      foreach (ops[i]) begin
         issue(ops[i], rand_word(), rand_word(), 1'b1);
         issue(ops[i], rand_word(), rand_word(), 1'b0);
      end
      // Slbi on a window address must leave memory alone
      repeat (4) begin
         addr = rand_addr();
         issue(op_slbi, addr, rand_word(), rand_bit());
         issue(op_ld, addr, 16'h0000, 1'b1);
      end
      close_test();
   endtask

   task automatic link_jumps();
      open_test("link");
      for (int n = 0; n < link_len; n++) begin
         issue((n % 2 == 0) ? op_jal : op_jalr, rand_word(), rand_word(), 1'b1);
      end
      close_test();
   endtask

   function automatic logic [opcode_w-1:0] mixed_op(input int k);
      case (k)
         0: return op_st;
         1: return op_ld;
         2: return op_stu;
         3: return op_slbi;
         4: return op_jal;
         5: return op_jalr;
         6: return op_r_a;
         7: return op_r_b;
         8: return op_lbi;
         9: return op_btr;
         10: return 5'b01000;
         default: return op_nop;
      endcase
   endfunction

   task automatic mixed_stream();
      logic [opcode_w-1:0] op;
      logic [word_w-1:0]   alu;
      open_test("mixed");
      repeat (mixed_len) begin
         op = mixed_op(int'(rand_bits(4)) % 12);
         // Memory group stays inside the known window
         if (op[4:2] == op_mem_grp) begin
            alu = rand_addr();
         end else begin
            alu = rand_word();
         end
         issue(op, alu, rand_word(), rand_bit());
      end
      close_test();
   endtask

   initial begin : main
      rst = 1'b1;
      instruction = '0;
      pc_incr = '0;
      b_operand = '0;
      alu_result = '0;
      reg_write = 1'b1;
      apply_reset();
      store_load_pairs();
      store_update_checks();
      non_memory_ops();
      link_jumps();
      mixed_stream();
      $display("Tests passed: %0d, failed: %0d, mismatches: %0d",
               pass_tests, fail_tests, err_cnt);
      if (fail_tests == 0 && err_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- logic/mem_wb_top.sv
// Memory and write-back back end of the five-stage pipeline
// Takes each instruction from execute, writes back one cycle later
`timescale 1ns/1ps

module mem_wb_top (
   input  logic                          clk,
   input  logic                          rst,
   // Execute stage
   input  logic [mem_wb_pkg::word_w-1:0] instruction,
   input  logic [mem_wb_pkg::word_w-1:0] pc_incr,
   input  logic [mem_wb_pkg::word_w-1:0] b_operand,
   input  logic [mem_wb_pkg::word_w-1:0] alu_result,
   input  logic                          reg_write,
   // Register file write port
   output logic                          wb_en,
   output logic [mem_wb_pkg::reg_w-1:0]  wb_reg,
   output logic [mem_wb_pkg::word_w-1:0] wb_data
);
   import mem_wb_pkg::*;

   // Memory/write-back register contents
   logic [word_w-1:0] instruction_q;
   logic [word_w-1:0] pc_incr_q;
   logic [word_w-1:0] alu_result_q;
   logic [word_w-1:0] read_data_q;
   logic              reg_write_q;

   mem_stage u_mem (
      .clk           (clk),
      .rst           (rst),
      .instruction   (instruction),
      .pc_incr       (pc_incr),
      .b_operand     (b_operand),
      .alu_result    (alu_result),
      .reg_write     (reg_write),
      .instruction_q (instruction_q),
      .pc_incr_q     (pc_incr_q),
      .alu_result_q  (alu_result_q),
      .read_data_q   (read_data_q),
      .reg_write_q   (reg_write_q)
   );

   wb_stage u_wb (
      .instruction_q (instruction_q),
      .pc_incr_q     (pc_incr_q),
      .alu_result_q  (alu_result_q),
      .read_data_q   (read_data_q),
      .reg_write_q   (reg_write_q),
      .wb_en         (wb_en),
      .wb_reg        (wb_reg),
      .wb_data       (wb_data)
   );

endmodule

//--- logic/wb_stage.sv
// Write-back stage of the pipeline back end
// Picks the value and destination register from the registered instruction
// Purely combinational, feeds the register file write port
`timescale 1ns/1ps

module wb_stage (
   // From the memory/write-back register
   input  logic [mem_wb_pkg::word_w-1:0] instruction_q,
   input  logic [mem_wb_pkg::word_w-1:0] pc_incr_q,
   input  logic [mem_wb_pkg::word_w-1:0] alu_result_q,
   input  logic [mem_wb_pkg::word_w-1:0] read_data_q,
   input  logic                          reg_write_q,
   // To the register file
   output logic                          wb_en,
   output logic [mem_wb_pkg::reg_w-1:0]  wb_reg,
   output logic [mem_wb_pkg::word_w-1:0] wb_data
);
   import mem_wb_pkg::*;

   instr_u              instr_q;
   logic [opcode_w-1:0] opcode;

   assign instr_q = instruction_q;
   assign opcode = instr_q.r_fmt.opcode;

   // Write decision was made in execute
   assign wb_en = reg_write_q;

   ////////////////////////////////////////
   // Write-back value
   ////////////////////////////////////////

   always_comb begin
      case (opcode)
         // Loaded word
         op_ld: begin
            wb_data = read_data_q;
         end
         // Return address
         op_jal, op_jalr: begin
            wb_data = pc_incr_q;
         end
         // ALU result, also the updated base for stu
         default: begin
            wb_data = alu_result_q;
         end
      endcase
   end

   ////////////////////////////////////////
   // Destination register
   ////////////////////////////////////////

   always_comb begin
      case (opcode)
         // R-format rd in bits 4:2
         op_r_a, op_r_b: begin
            wb_reg = instr_q.r_fmt.rd;
         end
         op_jal, op_jalr: begin
            wb_reg = link_reg;
         end
         // Rs doubles as destination
         op_lbi, op_slbi, op_btr, op_stu: begin
            wb_reg = instr_q.i2_fmt.rs;
         end
         // I-format-1 rd in bits 7:5
         default: begin
            wb_reg = instr_q.i1_fmt.rd;
         end
      endcase
   end

endmodule

//--- logic/mem_stage.sv
// Memory stage of the pipeline back end
// Decodes the memory access, drives the data memory and registers the results
// into the memory/write-back pipeline register
`timescale 1ns/1ps

module mem_stage (
   input  logic                          clk,
   input  logic                          rst,
   // From the execute stage
   input  logic [mem_wb_pkg::word_w-1:0] instruction,
   input  logic [mem_wb_pkg::word_w-1:0] pc_incr,
   input  logic [mem_wb_pkg::word_w-1:0] b_operand,
   input  logic [mem_wb_pkg::word_w-1:0] alu_result,
   input  logic                          reg_write,
   // To the write-back stage
   output logic [mem_wb_pkg::word_w-1:0] instruction_q,
   output logic [mem_wb_pkg::word_w-1:0] pc_incr_q,
   output logic [mem_wb_pkg::word_w-1:0] alu_result_q,
   output logic [mem_wb_pkg::word_w-1:0] read_data_q,
   output logic                          reg_write_q
);
   import mem_wb_pkg::*;

   // Decode view of the incoming word
   instr_u              instr_d;
   logic [opcode_w-1:0] opcode;
   logic                mem_grp;

   // Memory controls
   logic                mem_en;
   logic                mem_wr;
   logic [word_w-1:0]   mem_addr;
   logic [word_w-1:0]   mem_wdata;
   logic [word_w-1:0]   read_data;

   ////////////////////////////////////////
   // Access decode
   ////////////////////////////////////////

   assign instr_d = instruction;
   // Opcode sits in the same place in every format
   assign opcode = instr_d.r_fmt.opcode;

   // Top bits 100 mark the memory group
   assign mem_grp = (opcode[4:2] == op_mem_grp);

   // St, ld and stu access memory
   // Slbi shares the group but only goes through the ALU
   assign mem_en = mem_grp && (opcode[1:0] != op_slbi[1:0]);

   // Equal low bits pick st and stu
   assign mem_wr = mem_grp && (opcode[1] == opcode[0]);

   // Effective address computed in execute
   assign mem_addr = alu_result;
   // Store data is the B operand
   assign mem_wdata = b_operand;

   ////////////////////////////////////////
   // Data memory
   ////////////////////////////////////////

   data_mem u_dmem (
      .clk   (clk),
      .en    (mem_en),
      .wr    (mem_wr),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .rdata (read_data)
   );

   ////////////////////////////////////////
   // Memory/write-back register
   ////////////////////////////////////////

   // One instruction per edge, never stalls
   // B operand ends here as store data
   always_ff @(posedge clk) begin
      if (rst) begin
         instruction_q <= '0;
         pc_incr_q     <= '0;
         alu_result_q  <= '0;
         read_data_q   <= '0;
         reg_write_q   <= 1'b0;
      end else begin
         instruction_q <= instruction;
         pc_incr_q     <= pc_incr;
         alu_result_q  <= alu_result;
         // Zero unless a load or store was made
         read_data_q   <= read_data;
         reg_write_q   <= reg_write;
      end
   end

endmodule

//--- logic/data_mem.sv
// Word-addressed data memory used by the memory stage
// Read is combinational, a write lands on the rising clock edge
`timescale 1ns/1ps

module data_mem (
   input  logic                          clk,
   input  logic                          en,
   input  logic                          wr,
   input  logic [mem_wb_pkg::word_w-1:0] addr,
   input  logic [mem_wb_pkg::word_w-1:0] wdata,
   output logic [mem_wb_pkg::word_w-1:0] rdata
);
   import mem_wb_pkg::*;

   ////////////////////////////////////////
   // Storage
   ////////////////////////////////////////

   // Contents undefined until first written
   logic [word_w-1:0] mem [mem_depth];

   // Word index from the byte address
   logic [mem_aw-1:0] word_idx;
   logic              write_en;

   // Low bit dropped, no alignment check
   // Bits above the window wrap onto it
   assign word_idx = addr[mem_aw:1];

   // Write only when the access is enabled
   assign write_en = en && wr;

   ////////////////////////////////////////
   // Read port
   ////////////////////////////////////////

   // Same-cycle read
   // Quiet bus when no access is made
   always_comb begin
      if (en) begin
         rdata = mem[word_idx];
      end else begin
         rdata = '0;
      end
   end

   ////////////////////////////////////////
   // Write port
   ////////////////////////////////////////

   // Store lands at this edge
   // A load on the next cycle sees it
   always_ff @(posedge clk) begin
      if (write_en) begin
         mem[word_idx] <= wdata;
      end
   end

endmodule

//--- logic/mem_wb_pkg.sv
// Opcodes, widths and instruction formats for the memory and write-back stages
// Imported by every stage module and by the testbench
package mem_wb_pkg;

   ////////////////////////////////////////
   // Widths and sizes
   ////////////////////////////////////////

   // Data and address width
   localparam int word_w = 16;
   // Register index width
   localparam int reg_w = 3;
   // Opcode field width
   localparam int opcode_w = 5;
   // Data memory word index, 256 words
   localparam int mem_aw = 8;
   localparam int mem_depth = 1 << mem_aw;

   ////////////////////////////////////////
   // Opcodes
   ////////////////////////////////////////

   // Memory group, top three opcode bits
   localparam logic [2:0] op_mem_grp = 3'b100;
   localparam logic [opcode_w-1:0] op_st = 5'b10000;
   localparam logic [opcode_w-1:0] op_ld = 5'b10001;
   // Store with base register update
   localparam logic [opcode_w-1:0] op_stu = 5'b10011;
   // Shift and load byte, sits inside the memory group but never accesses memory
   localparam logic [opcode_w-1:0] op_slbi = 5'b10010;

   // Link jumps
   localparam logic [opcode_w-1:0] op_jal = 5'b00110;
   localparam logic [opcode_w-1:0] op_jalr = 5'b00111;

   // Register-register arithmetic and shifts
   localparam logic [opcode_w-1:0] op_r_a = 5'b11011;
   localparam logic [opcode_w-1:0] op_r_b = 5'b11010;

   // Immediate into Rs
   localparam logic [opcode_w-1:0] op_lbi = 5'b11000;
   localparam logic [opcode_w-1:0] op_btr = 5'b11001;

   // Link destination
   localparam logic [reg_w-1:0] link_reg = 3'd7;

   ////////////////////////////////////////
   // Instruction formats
   ////////////////////////////////////////

   typedef struct packed {
      logic [opcode_w-1:0] opcode;
      logic [reg_w-1:0]    rs;
      logic [reg_w-1:0]    rt;
      logic [reg_w-1:0]    rd;
      logic [1:0]          func;
   } r_fmt_t;

   // Five-bit immediate
   typedef struct packed {
      logic [opcode_w-1:0] opcode;
      logic [reg_w-1:0]    rs;
      logic [reg_w-1:0]    rd;
      logic [4:0]          imm5;
   } i1_fmt_t;

   // Eight-bit immediate, Rs is also the destination
   typedef struct packed {
      logic [opcode_w-1:0] opcode;
      logic [reg_w-1:0]    rs;
      logic [7:0]          imm8;
   } i2_fmt_t;

   // One instruction word seen three ways
   typedef union packed {
      r_fmt_t  r_fmt;
      i1_fmt_t i1_fmt;
      i2_fmt_t i2_fmt;
   } instr_u;

endpackage
